// File: hw/request_block.sv
////////////////////////////////////////////////////////////
// Master side of the bank: pad, arbitrate, test-and-set, decode
// Padded masters never request and never see a response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module request_block
(
    input  logic                                         clk,
    input  logic                                         rst_i,
    // Masters
    input  logic [`TCDM_N_CH-1:0]                        req_i,
    input  tcdm_pkg::tcdm_req_t [`TCDM_N_CH-1:0]         req_data_i,
    output logic [`TCDM_N_CH-1:0]                        gnt_o,
    // Bank request
    output logic                                         mem_req_o,
    output tcdm_pkg::tcdm_mem_req_t                      mem_data_o,
    input  logic                                         mem_gnt_i,
    // Bank response
    input  tcdm_pkg::tcdm_resp_t                         resp_i,
    output logic [`TCDM_N_CH-1:0]                        r_valid_o,
    output logic [`TCDM_DATA_W-1:0]                      r_rdata_o
);

    localparam int N_CH  = `TCDM_N_CH;
    localparam int N_PAD = `TCDM_N_PAD;

    logic [N_PAD-1:0]                          req_pad;
    tcdm_pkg::tcdm_mem_req_t [N_PAD-1:0]       data_pad;
    logic [N_PAD-1:0]                          gnt_pad;

    ////////////////////////////////////////////////////////////
    // Padding and one-hot IDs
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < N_PAD; i++)
    begin : g_pad
        if (i < N_CH)
        begin : g_real
            assign req_pad[i]  = req_i[i];
            assign data_pad[i] = '{req: req_data_i[i], id: N_PAD'(1) << i, ts_set: 1'b0};
            assign gnt_o[i]    = gnt_pad[i];
        end
        else
        begin : g_idle
            assign req_pad[i]  = 1'b0;     // Never wins, so its grant stays low
            assign data_pad[i] = '0;
        end
    end

    if (N_CH > 1)
    begin : g_poly
        logic                        arb_req;
        tcdm_pkg::tcdm_mem_req_t     arb_data;
        logic                        arb_gnt;

        rr_arb_tree rr_arb_tree_inst (
            .clk    ( clk        ),
            .rst_i  ( rst_i      ),
            .req_i  ( req_pad    ),
            .data_i ( data_pad   ),
            .gnt_o  ( gnt_pad    ),
            .req_o  ( arb_req    ),
            .data_o ( arb_data   ),
            .gnt_i  ( arb_gnt    )   // Low during the set cycle
        );

        test_and_set test_and_set_inst (
            .clk    ( clk        ),
            .rst_i  ( rst_i      ),
            .req_i  ( arb_req    ),
            .data_i ( arb_data   ),
            .gnt_o  ( arb_gnt    ),
            .req_o  ( mem_req_o  ),
            .data_o ( mem_data_o ),
            .gnt_i  ( mem_gnt_i  )
        );
    end
    else
    begin : g_mono
        // Single master, nothing to arbitrate
        test_and_set test_and_set_inst (
            .clk    ( clk         ),
            .rst_i  ( rst_i       ),
            .req_i  ( req_pad[0]  ),
            .data_i ( data_pad[0] ),
            .gnt_o  ( gnt_pad[0]  ),
            .req_o  ( mem_req_o   ),
            .data_o ( mem_data_o  ),
            .gnt_i  ( mem_gnt_i   )
        );
    end

    // Response ID back to a per-master valid, real masters only
    for (genvar i = 0; i < N_CH; i++)
    begin : g_rvalid
        assign r_valid_o[i] = resp_i.valid & resp_i.id[i];
    end

    assign r_rdata_o = resp_i.rdata;   // Shared read bus

endmodule

// File: hw/rr_arb_tree.sv
////////////////////////////////////////////////////////////
// Round-robin binary arbitration tree, combinational grant
// Needs a power-of-two width of at least two
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module rr_arb_tree
(
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic [`TCDM_N_PAD-1:0]                       req_i,
    input  tcdm_pkg::tcdm_mem_req_t [`TCDM_N_PAD-1:0]    data_i,
    output logic [`TCDM_N_PAD-1:0]                       gnt_o,
    output logic                                         req_o,
    output tcdm_pkg::tcdm_mem_req_t                      data_o,
    input  logic                                         gnt_i
);

    localparam int N   = `TCDM_N_PAD;
    localparam int LVL = $clog2(N);

    logic [LVL-1:0]          rr_q;      // Round-robin pointer
    logic [2*N-2:0]          node_req;  // Heap order, node 0 is the root
    logic [2*N-2:0]          node_gnt;
    tcdm_pkg::tcdm_mem_req_t node_data [2*N-1];

    ////////////////////////////////////////////////////////////
    // Leaves
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < N; i++)
    begin : g_leaf
        assign node_req[N-1+i]  = req_i[i];
        assign node_data[N-1+i] = data_i[i];
        assign gnt_o[i]         = node_gnt[N-1+i];   // Already masked by request
    end

    ////////////////////////////////////////////////////////////
    // Two-input arbiters, level 0 is the root
    ////////////////////////////////////////////////////////////
    for (genvar l = 0; l < LVL; l++)
    begin : g_lvl
        for (genvar k = 0; k < 2**l; k++)
        begin : g_node
            localparam int IDX = 2**l - 1 + k;
            localparam int LC  = 2*IDX + 1;
            localparam int RC  = 2*IDX + 2;

            logic sel_r;   // Right child wins

            // On a tie the pointer bit of this level decides
            // Leaf level uses bit 0 so neighbours alternate fastest
            assign sel_r = node_req[RC] & (~node_req[LC] | rr_q[LVL-1-l]);

            assign node_req[IDX]  = node_req[LC] | node_req[RC];
            assign node_data[IDX] = sel_r ? node_data[RC] : node_data[LC];

            // Grant goes back only down the winning path
            assign node_gnt[LC] = node_gnt[IDX] & node_req[LC] & ~sel_r;
            assign node_gnt[RC] = node_gnt[IDX] & sel_r;
        end
    end

    // Root side
    assign req_o       = node_req[0];
    assign data_o      = node_data[0];
    assign node_gnt[0] = gnt_i;

    // Pointer moves on every accepted transfer, wraps modulo N
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            rr_q <= '0;
        end
        else if (req_o && gnt_i)
        begin
            rr_q <= rr_q + 1'b1;
        end
    end

endmodule

// File: hw/tcdm_bank.sv
////////////////////////////////////////////////////////////
// Single-port word memory, no wait states
// Response one cycle after the access, none for a set store
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_bank
(
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  tcdm_pkg::tcdm_mem_req_t     data_i,
    output tcdm_pkg::tcdm_resp_t        resp_o
);

    localparam int DEPTH = 2 ** `TCDM_ADDR_W;
    localparam int BE_W  = `TCDM_BE_W;

    logic [`TCDM_DATA_W-1:0]   mem [DEPTH];   // Storage
    logic                      valid_q;
    logic [`TCDM_N_PAD-1:0]    id_q;          // ID of the answered request
    logic [`TCDM_DATA_W-1:0]   rdata_q;       // Word before the access
    logic                      answer;        // Access that owes a response

    assign answer = req_i & ~data_i.ts_set;

    ////////////////////////////////////////////////////////////
    // Byte-enable write
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (req_i && !data_i.req.wen)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (data_i.req.be[b])
                begin
                    mem[data_i.req.add][8*b +: 8] <= data_i.req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data and ID, old word on a store too
    always_ff @(posedge clk)
    begin
        if (answer)
        begin
            rdata_q <= mem[data_i.req.add];
            id_q    <= data_i.id;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= answer;   // One-cycle pulse
        end
    end

    assign resp_o.valid = valid_q;
    assign resp_o.id    = id_q;
    assign resp_o.rdata = rdata_q;

endmodule

// File: hw/tcdm_cfg.svh
////////////////////////////////////////////////////////////
// Build-time sizes of the TCDM request path
// TCDM_N_PAD is the master count rounded up to a power of two
////////////////////////////////////////////////////////////

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// Number of masters sharing the bank
`define TCDM_N_CH   5

// Word address width, 64 words
`define TCDM_ADDR_W 6

`define TCDM_DATA_W 32                   // Bank word width
`define TCDM_BE_W   (`TCDM_DATA_W / 8)   // One enable per byte

// Arbitration tree width
`define TCDM_N_PAD  (2 ** $clog2(`TCDM_N_CH))

`endif

// File: hw/tcdm_pkg.sv
////////////////////////////////////////////////////////////
// Request and response records of the TCDM path
// Field widths come from the cfg header
////////////////////////////////////////////////////////////

`include "tcdm_cfg.svh"

package tcdm_pkg;

    // One master's request
    // ts sits above add, so {ts, add} is the extended address
    typedef struct packed {
        logic                      ts;     // Test-and-set flag
        logic [`TCDM_ADDR_W-1:0]   add;    // Word address
        logic                      wen;    // 1 load, 0 store
        logic [`TCDM_DATA_W-1:0]   wdata;
        logic [`TCDM_BE_W-1:0]     be;
    } tcdm_req_t;

    // Request after arbitration, heading for the bank
    typedef struct packed {
        tcdm_req_t                 req;
        logic [`TCDM_N_PAD-1:0]    id;     // One-hot master ID
        logic                      ts_set; // Inserted set store
    } tcdm_mem_req_t;

    // Bank response, one cycle after the access
    typedef struct packed {
        logic                      valid;
        logic [`TCDM_N_PAD-1:0]    id;
        logic [`TCDM_DATA_W-1:0]   rdata;
    } tcdm_resp_t;

endpackage

// File: hw/tcdm_top.sv
////////////////////////////////////////////////////////////
// Shared TCDM bank with its master-side request path
// Bank never stalls, so the memory grant is tied high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_top
(
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic [`TCDM_N_CH-1:0]                        req_i,
    input  tcdm_pkg::tcdm_req_t [`TCDM_N_CH-1:0]         req_data_i,
    output logic [`TCDM_N_CH-1:0]                        gnt_o,
    output logic [`TCDM_N_CH-1:0]                        r_valid_o,
    output logic [`TCDM_DATA_W-1:0]                      r_rdata_o
);

    logic                        bank_req;
    tcdm_pkg::tcdm_mem_req_t     bank_data;
    tcdm_pkg::tcdm_resp_t        bank_resp;

    request_block request_block_inst (
        .clk        ( clk        ),
        .rst_i      ( rst_i      ),
        .req_i      ( req_i      ),
        .req_data_i ( req_data_i ),
        .gnt_o      ( gnt_o      ),
        .mem_req_o  ( bank_req   ),
        .mem_data_o ( bank_data  ),
        .mem_gnt_i  ( 1'b1       ),   // Zero wait states
        .resp_i     ( bank_resp  ),
        .r_valid_o  ( r_valid_o  ),
        .r_rdata_o  ( r_rdata_o  )
    );

    tcdm_bank tcdm_bank_inst (
        .clk    ( clk       ),
        .rst_i  ( rst_i     ),
        .req_i  ( bank_req  ),
        .data_i ( bank_data ),
        .resp_o ( bank_resp )
    );

endmodule

// File: hw/test_and_set.sv
////////////////////////////////////////////////////////////
// Test-and-set: a flagged load is followed by an all-ones store
// Upstream grant drops for the one set cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module test_and_set
(
    input  logic                        clk,
    input  logic                        rst_i,
    // Network side
    input  logic                        req_i,
    input  tcdm_pkg::tcdm_mem_req_t     data_i,
    output logic                        gnt_o,
    // Bank side
    output logic                        req_o,
    output tcdm_pkg::tcdm_mem_req_t     data_o,
    input  logic                        gnt_i
);

    typedef enum logic {
        TS_IDLE,
        TS_SET
    } ts_state_e;

    ts_state_e                  state_q;
    logic [`TCDM_ADDR_W-1:0]    set_add_q;   // Target of the pending set
    logic [`TCDM_N_PAD-1:0]     set_id_q;
    logic                       ts_hit;      // Granted test-and-set load

    assign ts_hit = req_i & gnt_i & data_i.req.wen & data_i.req.ts;

    ////////////////////////////////////////////////////////////
    // Output mux
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        req_o       = req_i;              // Idle: straight through
        data_o      = data_i;
        data_o.ts_set = 1'b0;
        gnt_o       = gnt_i;
        if (state_q == TS_SET)
        begin
            req_o            = 1'b1;      // Set store owns the bank
            data_o.req.ts    = 1'b0;
            data_o.req.add   = set_add_q;
            data_o.req.wen   = 1'b0;      // Store
            data_o.req.wdata = '1;
            data_o.req.be    = '1;        // Whole word
            data_o.id        = set_id_q;
            data_o.ts_set    = 1'b1;
            gnt_o            = 1'b0;      // Hold the tree off
        end
    end

    // State, the set leaves only once the bank takes it
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= TS_IDLE;
        end
        else if (state_q == TS_IDLE)
        begin
            if (ts_hit)
            begin
                state_q <= TS_SET;
            end
        end
        else if (gnt_i)
        begin
            state_q <= TS_IDLE;
        end
    end

    // Address and ID captured with the load
    always_ff @(posedge clk)
    begin
        if (state_q == TS_IDLE && ts_hit)
        begin
            set_add_q <= data_i.req.add;
            set_id_q  <= data_i.id;
        end
    end

endmodule

// File: test/tb_tcdm.sv
////////////////////////////////////////////////////////////
// Random traffic on all masters against a word model of the bank
// Words 0 to 15 are preloaded by master 0 before random traffic
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tb_tcdm;

    localparam int N_CH     = `TCDM_N_CH;
    localparam int N_PAD    = `TCDM_N_PAD;
    localparam int DATA_W   = `TCDM_DATA_W;
    localparam int N_WORDS  = 16;                 // Hot address range
    localparam int N_GRANTS = 2000;
    localparam int WAIT_MAX = 2 * N_PAD;          // Fairness bound in cycles
    localparam int TIMEOUT  = (N_GRANTS + N_WORDS) * WAIT_MAX + 500;

    typedef struct packed {
        logic [N_CH-1:0]   mask;     // Expected r_valid_o
        logic              is_load;
        logic [DATA_W-1:0] data;     // Word before the access
    } exp_t;

    logic                                 clk;
    logic                                 rst_i;
    logic [N_CH-1:0]                      req;
    tcdm_pkg::tcdm_req_t [N_CH-1:0]       req_data;
    logic [N_CH-1:0]                      gnt;
    logic [N_CH-1:0]                      r_valid;
    logic [DATA_W-1:0]                    r_rdata;

    logic [DATA_W-1:0] model [2**`TCDM_ADDR_W];  // Mirror of the bank
    exp_t              exp_q [$];
    logic [N_CH-1:0]   last_gnt;                 // Grants seen at the last rising edge
    logic                          set_pending;
    logic [`TCDM_ADDR_W-1:0]       set_add;
    int                wait_cnt [N_CH];
    int                err_cnt;
    int                n_grants;
    int                n_resp;
    int                n_ts;
    int                cyc;
    bit                stop;

    tcdm_pkg::tcdm_req_t gd;   // Granted request, monitor scratch
    exp_t                e;

    tcdm_top tcdm_top_inst (
        .clk        ( clk      ),
        .rst_i      ( rst_i    ),
        .req_i      ( req      ),
        .req_data_i ( req_data ),
        .gnt_o      ( gnt      ),
        .r_valid_o  ( r_valid  ),
        .r_rdata_o  ( r_rdata  )
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic report_counts();
        $display("errors %0d, grants %0d, responses %0d, test-and-set %0d",
                 err_cnt, n_grants, n_resp, n_ts);
    endtask

    // Random request, loads and stores weighted evenly
    function automatic tcdm_pkg::tcdm_req_t draw_req();
        tcdm_pkg::tcdm_req_t r;
        int unsigned         kind;
        kind    = $urandom_range(9);
        r.add   = $urandom_range(N_WORDS - 1);
        r.wdata = $urandom;
        r.be    = $urandom;
        r.wen   = (kind < 4) || (kind >= 8);
        r.ts    = (kind >= 8);                   // Test-and-set load
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus, driven on the falling edge
    ////////////////////////////////////////////////////////////
    initial
    begin
        clk      = 1'b0;
        rst_i    = 1'b1;
        req      = '0;
        req_data = '0;
        stop     = 1'b0;
        void'($urandom(32'h948e));
        repeat (2) @(posedge clk);
        @(negedge clk) rst_i = 1'b0;

        // Known contents for the hot words
        for (int a = 0; a < N_WORDS; a++)
        begin
            req[0]            = 1'b1;
            req_data[0]       = '0;
            req_data[0].add   = a;
            req_data[0].wdata = $urandom;
            req_data[0].be    = '1;
            do @(negedge clk); while (!last_gnt[0]);
        end
        req[0] = 1'b0;

        while (req != '0 || !stop)
        begin
            @(negedge clk);
            stop = (n_grants >= N_GRANTS);   // Then drain what is pending
            for (int m = 0; m < N_CH; m++)
            begin
                if (last_gnt[m])
                begin
                    req[m] = 1'b0;           // Release after the grant edge
                end
                else if (!req[m] && !stop && $urandom_range(1))
                begin
                    req_data[m] = draw_req();
                    req[m]      = 1'b1;
                end
            end
        end
        repeat (3) @(posedge clk);

        if (exp_q.size() != 0 || n_resp != n_grants)
        begin
            $display("Response count %0d does not match grant count %0d", n_resp, n_grants);
            err_cnt++;
        end
        report_counts();
        if (err_cnt == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Monitor and model, on the rising edge
    ////////////////////////////////////////////////////////////
    initial
    begin
        err_cnt     = 0;
        n_grants    = 0;
        n_resp      = 0;
        n_ts        = 0;
        cyc         = 0;
        last_gnt    = '0;
        set_pending = 1'b0;
        for (int m = 0; m < N_CH; m++)
        begin
            wait_cnt[m] = 0;
        end
    end

    always @(posedge clk)
    begin
        if (rst_i)
        begin
            last_gnt = '0;
        end
        else if (cyc > TIMEOUT)
        begin
            $display("Run timed out after %0d cycles with %0d grants", cyc, n_grants);
            report_counts();
            $display("sim failed");
            $finish;
        end
        else
        begin
            cyc++;
            if ((gnt & ~req) !== '0 || (gnt & (gnt - 1'b1)) !== '0)   // One-hot on a requester
            begin
                $display("MISMATCH at %0t: gnt %b for req %b", $time, gnt, req);
                err_cnt++;
            end
            if (set_pending)                        // Set store owns this cycle
            begin
                if (gnt !== '0)
                begin
                    $display("MISMATCH at %0t: gnt %b in set cycle", $time, gnt);
                    err_cnt++;
                end
                model[set_add] = '1;
                set_pending    = 1'b0;
            end

            // Response owed by the previous grant
            if (r_valid != '0)
            begin
                n_resp++;
            end
            if (exp_q.size() > 0)
            begin
                e = exp_q.pop_front();
                if (r_valid !== e.mask)
                begin
                    $display("MISMATCH at %0t: r_valid %b, expected %b", $time, r_valid, e.mask);
                    err_cnt++;
                end
                else if (e.is_load && r_rdata !== e.data)
                begin
                    $display("MISMATCH at %0t: rdata %h, expected %h", $time, r_rdata, e.data);
                    err_cnt++;
                end
            end
            else if (r_valid !== '0)
            begin
                $display("MISMATCH at %0t: r_valid %b without a grant", $time, r_valid);
                err_cnt++;
            end

            for (int m = 0; m < N_CH; m++)
            begin
                if (req[m] && gnt[m])
                begin
                    gd = req_data[m];
                    n_grants++;
                    e.mask    = '0;
                    e.mask[m] = 1'b1;               // Only the granted master answers
                    e.is_load = gd.wen;
                    e.data    = model[gd.add];
                    exp_q.push_back(e);
                    if (gd.wen && gd.ts)            // All ones land next cycle
                    begin
                        set_pending = 1'b1;
                        set_add     = gd.add;
                        n_ts++;
                    end
                    else if (!gd.wen)
                    begin
                        for (int b = 0; b < `TCDM_BE_W; b++)
                        begin
                            if (gd.be[b])
                            begin
                                model[gd.add][8*b +: 8] = gd.wdata[8*b +: 8];
                            end
                        end
                    end
                end
                // Fairness, counted in waiting cycles
                wait_cnt[m] = (req[m] && !gnt[m]) ? wait_cnt[m] + 1 : 0;
                if (wait_cnt[m] == WAIT_MAX + 1)
                begin
                    $display("Master %0d waited more than %0d cycles for a grant", m, WAIT_MAX);
                    err_cnt++;
                end
            end
            last_gnt = gnt;
        end
    end

endmodule

// File: verilog.f
+incdir+hw
hw/tcdm_pkg.sv
hw/rr_arb_tree.sv
hw/test_and_set.sv
hw/request_block.sv
hw/tcdm_bank.sv
hw/tcdm_top.sv
test/tb_tcdm.sv
